/* i2s_in.sv */
`default_nettype none

`include "i2si_consts.svh"

module i2s_in (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        sck,             // I2S bit clock
    input  wire                        ws,              // I2S word select
    input  wire [`I2SI_NUM_LANES-1:0]  sd,              // One data pin per lane
    input  wire                        en,              // Receiver enable
    input  wire                        bist_en,         // Test generator replaces lanes
    input  wire [`I2SI_BIST_W-1:0]     bist_start_val,
    input  wire [`I2SI_BIST_INC_W-1:0] bist_inc,
    input  wire [`I2SI_BIST_W-1:0]     bist_up_limit,
    input  wire                        overrun_clr,     // Clear pulse for overrun
    output i2si_pkg::lane_t            out_lane,
    output i2si_pkg::sample_t          out_left,
    output i2si_pkg::sample_t          out_right,
    output logic                       out_rts,         // FIFO not empty
    input  wire                        out_rtr,         // Host reads head
    output logic                       overrun          // Sticky full FIFO flag
);

    logic                       sck_rise;
    logic                       ws_fall;
    logic                       ws_s;
    logic [`I2SI_NUM_LANES-1:0] sd_s;
    i2si_pkg::frame_t           in_data;
    logic                       in_rts;
    logic                       in_rtr;
    logic                       drop;
    i2si_pkg::frame_t           out_data;

    i2si_frame_if lane_if [`I2SI_NUM_LANES] ();
    i2si_frame_if bist_if ();

    i2si_pin_sync u_pin_sync (
        .clk      (clk),
        .rst      (rst),
        .sck      (sck),
        .ws       (ws),
        .sd       (sd),
        .sck_rise (sck_rise),
        .ws_fall  (ws_fall),
        .ws_s     (ws_s),
        .sd_s     (sd_s)
    );

    // Lanes run only with the test generator off
    for (genvar g = 0; g < `I2SI_NUM_LANES; g++)
    begin : g_lane
        i2si_deserializer #(.LANE(g)) u_deser (
            .clk      (clk),
            .rst      (rst),
            .en       (en && !bist_en),
            .sck_rise (sck_rise),
            .ws_fall  (ws_fall),
            .ws_s     (ws_s),
            .sd_bit   (sd_s[g]),
            .frame    (lane_if[g])
        );
    end

    i2si_bist_gen u_bist (
        .clk       (clk),
        .rst       (rst),
        .en        (en && bist_en),
        .ws_fall   (ws_fall),
        .start_val (bist_start_val),
        .inc       (bist_inc),
        .up_limit  (bist_up_limit),
        .frame     (bist_if)
    );

    i2si_collector u_collector (
        .clk     (clk),
        .rst     (rst),
        .bist_en (bist_en),
        .lanes   (lane_if),
        .bist    (bist_if),
        .in_data (in_data),
        .in_rts  (in_rts),
        .in_rtr  (in_rtr),
        .drop    (drop)
    );

    i2si_fifo #(
        .payload_t (i2si_pkg::frame_t),
        .DEPTH     (`I2SI_FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .in_data  (in_data),
        .in_rts   (in_rts),
        .in_rtr   (in_rtr),
        .out_data (out_data),
        .out_rts  (out_rts),
        .out_rtr  (out_rtr)
    );

    assign out_lane  = out_data.lane;
    assign out_left  = out_data.left;
    assign out_right = out_data.right;

    ////////////////////
    // Overrun flag

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            overrun <= 1'b0;
        else if (drop)
            overrun <= 1'b1;                // Set beats clear
        else if (overrun_clr)
            overrun <= 1'b0;
    end

endmodule

`default_nettype wire

/* i2s_in_patterns.txt */
# name mode frames backpressure clear, then data in hex
# lanes: per frame line, left right for lane 0..3; bist: start inc limit
deser lanes 3 0 0
1234 abcd 8000 7fff 0001 fffe a5a5 5a5a
ffff 0000 1357 2468 c3c3 3c3c 0f0f f0f0
4321 dcba 7ffe 8001 beef cafe 0102 0304
enable lanes 2 0 0
1111 2222 3333 4444 5555 6666 7777 8888
9999 aaaa bbbb cccc dddd eeee ffff 0001
bist_wrap bist 6 0 0
0f0 40 150
bist_carry bist 4 0 0
ff0 ff fff
backpressure lanes 3 1 0
0101 1010 0202 2020 0303 3030 0404 4040
0505 5050 0606 6060 0707 7070 0808 8080
0909 9090 0a0a a0a0 0b0b b0b0 0c0c c0c0
clear lanes 2 0 1
fedc ba98 7654 3210 0f1e 2d3c 4b5a 6978
8796 a5b4 c3d2 e1f0 1020 3040 5060 7080

/* i2s_in_tb.sv */
`default_nettype none

`include "i2si_consts.svh"

module i2s_in_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N = `I2SI_NUM_LANES;

    logic                        clk;
    logic                        rst;
    logic                        sck;
    logic                        ws;
    logic [N-1:0]                sd;
    logic                        en;
    logic                        bist_en;
    logic [`I2SI_BIST_W-1:0]     bist_start_val;
    logic [`I2SI_BIST_INC_W-1:0] bist_inc;
    logic [`I2SI_BIST_W-1:0]     bist_up_limit;
    logic                        overrun_clr;
    i2si_pkg::lane_t             out_lane;
    i2si_pkg::sample_t           out_left;
    i2si_pkg::sample_t           out_right;
    logic                        out_rts;
    logic                        out_rtr;
    logic                        overrun;

    // Test table from the pattern file
    string       tname [16];
    string       tmode [16];
    int          tnfr [16];
    int          tbp [16];
    int          tclr [16];
    int          woff [16];
    logic [15:0] words [1024];
    int          ntests;

    i2si_pkg::frame_t exp_q [$];        // Scoreboard
    i2si_pkg::frame_t exp_f;
    string            cur_name;
    logic [31:0]      rng;
    int               cycles;
    int               limit;

    i2s_in UUT (
        .clk            (clk),
        .rst            (rst),
        .sck            (sck),
        .ws             (ws),
        .sd             (sd),
        .en             (en),
        .bist_en        (bist_en),
        .bist_start_val (bist_start_val),
        .bist_inc       (bist_inc),
        .bist_up_limit  (bist_up_limit),
        .overrun_clr    (overrun_clr),
        .out_lane       (out_lane),
        .out_left       (out_left),
        .out_right      (out_right),
        .out_rts        (out_rts),
        .out_rtr        (out_rtr),
        .overrun        (overrun)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 8 ns period
    end

    ////////////////////
    // Helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string what, input logic [31:0] expv,
                             input logic [31:0] actv);
        if (expv !== actv)
            fail_run($sformatf("MISMATCH %s expected %h actual %h", what, expv, actv));
    endtask

    // One bit slot with sck low for 4 clk then high for 4 clk
    task automatic send_slot(input logic ws_v, input logic [N-1:0] sd_v);
        @(posedge clk);
        sck <= 1'b0;
        ws  <= ws_v;                    // ws and sd move on falling sck
        sd  <= sd_v;
        repeat (3) @(posedge clk);
        @(posedge clk);
        sck <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    // I2S slot j of frame f where data trails ws by one slot
    function automatic logic [N-1:0] slot_sd(input int t, input int f, input int j,
                                             input logic [N-1:0] plsb);
        logic [N-1:0] b;
        logic [15:0]  l;
        logic [15:0]  r;
        for (int k = 0; k < N; k++)
        begin
            l = words[woff[t] + f * 2 * N + 2 * k];
            r = words[woff[t] + f * 2 * N + 2 * k + 1];
            if (j == 0)
                b[k] = plsb[k];         // LSB of previous right word
            else if (j < 16)
                b[k] = l[16 - j];
            else if (j == 16)
                b[k] = l[0];
            else
                b[k] = r[32 - j];
        end
        return b;
    endfunction

    ////////////////////
    // FIFO reader and timeout

    always @(posedge clk)
    begin
        if (rst && out_rts && out_rtr)
        begin
            if (exp_q.size() == 0)
                fail_run({"Unexpected frame read from the FIFO in test ", cur_name});
            else
            begin
                exp_f = exp_q.pop_front();
                check_val({cur_name, " lane"}, {30'h0, exp_f.lane}, {30'h0, out_lane});
                check_val({cur_name, " left"}, {16'h0, exp_f.left}, {16'h0, out_left});
                check_val({cur_name, " right"}, {16'h0, exp_f.right}, {16'h0, out_right});
            end
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles > limit)
            fail_run("Timeout waiting for the expected frames");
    end

    ////////////////////
    // One test from the table

    task automatic run_test(input int t, inout logic ovr_exp);
        logic [N-1:0] plsb;
        logic [12:0]  v;
        int           nsend;
        cur_name = tname[t];
        en             <= 1'b0;
        bist_en        <= (tmode[t] == "bist");
        out_rtr        <= !tbp[t];
        bist_start_val <= words[woff[t]][11:0];
        bist_inc       <= words[woff[t] + 1][7:0];
        bist_up_limit  <= words[woff[t] + 2][11:0];
        repeat (4) @(posedge clk);
        if (tclr[t] != 0)
        begin
            overrun_clr <= 1'b1;
            @(posedge clk);
            overrun_clr <= 1'b0;
            repeat (2) @(posedge clk);
            check_val({cur_name, " overrun after clear"}, 0, {31'h0, overrun});
            ovr_exp = 1'b0;
        end
        // Predict frames
        if (tmode[t] == "bist")
        begin
            v = {1'b0, words[woff[t]][11:0]};
            for (int f = 0; f < tnfr[t]; f++)
            begin
                exp_q.push_back(i2si_pkg::frame_t'{2'd0, {v[11:0], 4'h0},
                                                   {v[11:0], 4'h0}});
                v = v + words[woff[t] + 1][7:0];
                if (v > {1'b0, words[woff[t] + 2][11:0]})
                    v = {1'b0, words[woff[t]][11:0]};
            end
            nsend = tnfr[t] - 1;        // Lead frame fall already emits one
        end
        else
        begin
            for (int f = 0; f < tnfr[t]; f++)
                for (int k = 0; k < N; k++)
                    if (tbp[t] == 0 || f * N + k < `I2SI_FIFO_DEPTH)
                        exp_q.push_back(i2si_pkg::frame_t'{k[1:0],
                                        words[woff[t] + f * 2 * N + 2 * k],
                                        words[woff[t] + f * 2 * N + 2 * k + 1]});
            nsend = tnfr[t];
        end
        // Lead frame of noise with en rising half way
        for (int j = 0; j < 32; j++)
        begin
            rng = xorshift32(rng);
            plsb = rng[N-1:0];
            send_slot(j >= 16, plsb);
            if (j == 7)
                en <= 1'b1;
        end
        for (int f = 0; f < nsend; f++)
        begin
            for (int j = 0; j < 32; j++)
                send_slot(j >= 16, (tmode[t] == "bist") ? '0 : slot_sd(t, f, j, plsb));
            for (int k = 0; k < N; k++)
                plsb[k] = words[woff[t] + f * 2 * N + 2 * k + 1][0];
        end
        send_slot(1'b0, (tmode[t] == "bist") ? '0 : plsb);     // Last right LSB
        repeat (3) send_slot(1'b0, '0);
        en <= 1'b0;
        if (tbp[t] != 0)
        begin
            repeat (16) @(posedge clk);
            check_val({cur_name, " out_rts while held"}, 1, {31'h0, out_rts});
            check_val({cur_name, " overrun while held"}, 1, {31'h0, overrun});
            ovr_exp = 1'b1;
            out_rtr <= 1'b1;
        end
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (40) @(posedge clk);
        check_val({cur_name, " out_rts after drain"}, 0, {31'h0, out_rts});
        check_val({cur_name, " overrun"}, {31'h0, ovr_exp}, {31'h0, overrun});
    endtask

    ////////////////////
    // Main sequence

    initial
    begin
        int    fd;
        int    r;
        int    nw;
        int    total;
        string tok;
        string line;
        logic  ovr_exp;
        rst = 1'b0;
        sck = 1'b0;
        ws = 1'b0;
        sd = '0;
        en = 1'b0;
        bist_en = 1'b0;
        bist_start_val = '0;
        bist_inc = '0;
        bist_up_limit = '0;
        overrun_clr = 1'b0;
        out_rtr = 1'b0;
        rng = 32'h1170f413;
        cycles = 0;
        limit = 1000;
        ntests = 0;
        nw = 0;
        total = 0;
        ovr_exp = 1'b0;
        fd = $fopen("i2s_in_patterns.txt", "r");
        if (fd == 0)
            fail_run("Cannot open i2s_in_patterns.txt");
        while (!$feof(fd))
        begin
            r = $fscanf(fd, "%s", tok);
            if (r != 1)
                break;
            if (tok.getc(0) == 8'h23)
                r = $fgets(line, fd);   // Skip comment line
            else
            begin
                tname[ntests] = tok;
                r = $fscanf(fd, "%s %d %d %d", tmode[ntests], tnfr[ntests],
                            tbp[ntests], tclr[ntests]);
                woff[ntests] = nw;
                for (int i = 0; i < ((tmode[ntests] == "bist") ? 3 : tnfr[ntests] * 2 * N); i++)
                begin
                    r = $fscanf(fd, "%h", words[nw]);
                    nw++;
                end
                total += tnfr[ntests] + 2;      // Lead and tail periods too
                ntests++;
            end
        end
        $fclose(fd);
        limit = 2 * (total * 32 * 8 + 200);
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        for (int t = 0; t < ntests; t++)
            run_test(t, ovr_exp);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* i2si_bist_gen.sv */
`default_nettype none

`include "i2si_consts.svh"

module i2si_bist_gen (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        en,          // Generator enable level
    input  wire                        ws_fall,     // One frame per strobe
    input  wire [`I2SI_BIST_W-1:0]     start_val,   // Reload value
    input  wire [`I2SI_BIST_INC_W-1:0] inc,         // Step per frame
    input  wire [`I2SI_BIST_W-1:0]     up_limit,    // Wrap above this
    i2si_frame_if.source               frame
);

    localparam int BW = `I2SI_BIST_W;
    localparam int IW = `I2SI_BIST_INC_W;
    localparam int SW = `I2SI_SAMPLE_W;

    logic [BW-1:0]     cnt;
    logic [BW:0]       sum;                 // One extra bit for carry
    i2si_pkg::sample_t value;

    assign sum = {1'b0, cnt} + {{(BW - IW + 1){1'b0}}, inc};

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            cnt       <= '0;
            frame.xfc <= 1'b0;
        end
        else
        begin
            frame.xfc <= en && ws_fall;     // Frame 1 clk after strobe
            if (!en)
                cnt <= start_val;           // Hold at start while idle
            else if (ws_fall)
            begin
                if (sum > {1'b0, up_limit})
                    cnt <= start_val;
                else
                    cnt <= sum[BW-1:0];
            end
        end
    end

    // Counter goes in the MSBs, low bits zero
    always_ff @(posedge clk)
    begin
        if (ws_fall)
            value <= {cnt, {(SW - BW){1'b0}}};
    end

    assign frame.lane  = '0;
    assign frame.left  = value;
    assign frame.right = value;             // Same value on both channels

endmodule

`default_nettype wire

/* i2si_collector.sv */
`default_nettype none

`include "i2si_consts.svh"

module i2si_collector (
    input  wire              clk,
    input  wire              rst,
    input  wire              bist_en,                      // Take test frames only
    i2si_frame_if.sink       lanes [`I2SI_NUM_LANES],
    i2si_frame_if.sink       bist,
    output i2si_pkg::frame_t in_data,                      // FIFO write data
    output logic             in_rts,                       // FIFO write strobe
    input  wire              in_rtr,                       // FIFO not full
    output logic             drop                          // Write lost to full FIFO
);

    localparam int N = `I2SI_NUM_LANES;

    logic [N-1:0]     src_xfc;
    i2si_pkg::frame_t src_frame [N];
    logic [N-1:0]     pend_valid;       // Slot holds an unwritten frame
    i2si_pkg::frame_t pend_frame [N];
    logic [N-1:0]     grant;            // Slot written this clk

    ////////////////////
    // Source select

    for (genvar i = 0; i < N; i++)
    begin : g_src
        if (i == 0)
        begin : g_bist_mux
            // Test generator shares slot 0 with lane 0
            assign src_xfc[i]   = bist_en ? bist.xfc : lanes[i].xfc;
            assign src_frame[i] = bist_en ? {bist.lane, bist.left, bist.right}
                                          : {lanes[i].lane, lanes[i].left, lanes[i].right};
        end
        else
        begin : g_lane
            assign src_xfc[i]   = !bist_en && lanes[i].xfc;
            assign src_frame[i] = {lanes[i].lane, lanes[i].left, lanes[i].right};
        end
    end

    ////////////////////
    // Pending slots and drain

    // Lowest pending index wins
    always_comb
    begin
        grant   = '0;
        in_data = pend_frame[0];
        for (int k = N - 1; k >= 0; k--)
        begin
            if (pend_valid[k])
            begin
                grant    = '0;
                grant[k] = 1'b1;
                in_data  = pend_frame[k];
            end
        end
    end

    assign in_rts = |pend_valid;
    assign drop   = in_rts && !in_rtr;  // FIFO full so frame is lost

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            pend_valid <= '0;
        else
        begin
            for (int k = 0; k < N; k++)
            begin
                if (src_xfc[k])
                    pend_valid[k] <= 1'b1;
                else if (grant[k])
                    pend_valid[k] <= 1'b0;  // Written or dropped
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int k = 0; k < N; k++)
        begin
            if (src_xfc[k])
                pend_frame[k] <= src_frame[k];
        end
    end

    // Producers must not outrun the drain
    for (genvar i = 0; i < N; i++)
    begin : g_chk
        a_slot_free : assert property (@(posedge clk) disable iff (!rst)
            src_xfc[i] |-> (!pend_valid[i] || grant[i]));
    end

endmodule

`default_nettype wire

/* i2si_consts.svh */
`ifndef I2SI_CONSTS_SVH
`define I2SI_CONSTS_SVH

////////////////////
// Audio format

`define I2SI_NUM_LANES  4       // Serial data pins sharing sck and ws
`define I2SI_SAMPLE_W   16      // Bits kept per channel word

////////////////////
// Buffering

`define I2SI_FIFO_DEPTH 8       // Frames held for the host

////////////////////
// Test generator

`define I2SI_BIST_W     12      // Counter width
`define I2SI_BIST_INC_W 8       // Step width

`endif

/* i2si_deserializer.sv */
`default_nettype none

`include "i2si_consts.svh"

module i2si_deserializer #(
    parameter int LANE = 0                // Lane index put on each frame
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         en,               // Lane enable level
    input  wire         sck_rise,         // Bit sample strobe
    input  wire         ws_fall,          // Frame end strobe
    input  wire         ws_s,             // Synced ws level
    input  wire         sd_bit,           // Synced data for this lane
    i2si_frame_if.source frame
);

    localparam int SW = `I2SI_SAMPLE_W;
    localparam int CW = $clog2(SW + 1);

    logic              ws_d;              // ws at previous sck rise
    logic [CW-1:0]     cnt;               // Bits taken in current word
    logic              armed;             // Seen a ws fall while enabled
    i2si_pkg::sample_t shreg;             // MSB first shift register
    i2si_pkg::sample_t left_hold;         // Finished left word
    i2si_pkg::sample_t word_next;         // Word as it stands with current bit
    i2si_pkg::sample_t right_q;

    // Short word still needs the bit on sd appended
    // Long words already hold their 16 MSBs
    always_comb
    begin
        if (cnt < CW'(SW))
            word_next = {shreg[SW-2:0], sd_bit};
        else
            word_next = shreg;
    end

    ////////////////////
    // Control

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ws_d      <= 1'b0;
            cnt       <= '0;
            armed     <= 1'b0;
            frame.xfc <= 1'b0;
        end
        else
        begin
            frame.xfc <= armed && en && ws_fall;    // First ws fall only arms
            if (!en)
                armed <= 1'b0;
            else if (ws_fall)
                armed <= 1'b1;
            if (sck_rise)
            begin
                ws_d <= ws_s;
                // ws changed since last rise so this bit ends the word
                if (ws_s != ws_d)
                    cnt <= '0;
                else if (cnt < CW'(SW))
                    cnt <= cnt + 1'b1;
            end
        end
    end

    ////////////////////
    // Data path

    always_ff @(posedge clk)
    begin
        if (sck_rise)
        begin
            if (ws_s != ws_d)
            begin
                if (!ws_d)
                    left_hold <= word_next;         // ws rose so left word is done
            end
            else if (cnt < CW'(SW))
                shreg <= {shreg[SW-2:0], sd_bit};
        end
        // Right LSB already sits on sd when the ws fall strobe arrives
        if (ws_fall)
            right_q <= word_next;
    end

    assign frame.lane  = i2si_pkg::lane_t'(LANE);
    assign frame.left  = left_hold;                 // Stable for half a frame
    assign frame.right = right_q;

endmodule

`default_nettype wire

/* i2si_fifo.sv */
`default_nettype none

module i2si_fifo #(
    parameter type payload_t = logic [7:0],    // Stored word type
    parameter int  DEPTH     = 8
) (
    input  wire      clk,
    input  wire      rst,
    input  var       payload_t in_data,
    input  wire      in_rts,                   // Write request
    output logic     in_rtr,                   // Room for a write
    output payload_t out_data,                 // Head entry shown fall through
    output logic     out_rts,                  // Data available
    input  wire      out_rtr                   // Consumer takes head
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;                      // Entries in use
    logic          push;
    logic          pop;

    assign in_rtr   = count != CW'(DEPTH);
    assign out_rts  = count != '0;
    assign out_data = mem[rd_ptr];
    assign push     = in_rts && in_rtr;        // Write when full is ignored
    assign pop      = out_rts && out_rtr;

    ////////////////////
    // Pointers and count

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // Storage
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    a_count_max : assert property (@(posedge clk) disable iff (!rst)
        count <= CW'(DEPTH));

endmodule

`default_nettype wire

/* i2si_frame_if.sv */
`default_nettype none

// One stereo frame handed from a producer to the collector
// xfc is a single clk strobe and the fields only hold in that clk
interface i2si_frame_if;

    i2si_pkg::lane_t   lane;    // Source lane
    i2si_pkg::sample_t left;    // Left sample
    i2si_pkg::sample_t right;   // Right sample
    logic              xfc;     // Frame valid strobe

    // Deserializer or test generator side
    modport source (
        output lane,
        output left,
        output right,
        output xfc
    );

    // Collector side
    modport sink (
        input lane,
        input left,
        input right,
        input xfc
    );

endinterface

`default_nettype wire

/* i2si_pin_sync.sv */
`default_nettype none

`include "i2si_consts.svh"

module i2si_pin_sync (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        sck,       // Raw bit clock pin
    input  wire                        ws,        // Raw word select pin
    input  wire [`I2SI_NUM_LANES-1:0]  sd,        // Raw data pins
    output logic                       sck_rise,  // One clk per rising sck
    output logic                       ws_fall,   // One clk per falling ws
    output logic                       ws_s,      // ws in clk domain
    output logic [`I2SI_NUM_LANES-1:0] sd_s       // sd in clk domain
);

    logic                       sck_q1;
    logic                       sck_q2;
    logic                       sck_q3;   // Edge detect stage
    logic                       ws_q1;
    logic                       ws_q3;    // Edge detect stage
    logic [`I2SI_NUM_LANES-1:0] sd_q1;

    ////////////////////
    // Two-flop sync plus one history stage

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            sck_q1   <= 1'b0;
            sck_q2   <= 1'b0;
            sck_q3   <= 1'b0;
            ws_q1    <= 1'b0;
            ws_s     <= 1'b0;
            ws_q3    <= 1'b0;
            sd_q1    <= '0;
            sd_s     <= '0;
            sck_rise <= 1'b0;
            ws_fall  <= 1'b0;
        end
        else
        begin
            sck_q1   <= sck;
            sck_q2   <= sck_q1;
            sck_q3   <= sck_q2;
            ws_q1    <= ws;
            ws_s     <= ws_q1;              // Visible 2 clk after pin
            ws_q3    <= ws_s;
            sd_q1    <= sd;
            sd_s     <= sd_q1;
            // Registered strobes land 3 clk after the pin edge
            sck_rise <= sck_q2 & ~sck_q3;
            ws_fall  <= ~ws_s & ws_q3;
        end
    end

    // clk must oversample sck well enough that strobes stay apart
    // ws moves on falling sck so it never meets a rising strobe
    a_oversample : assert property (@(posedge clk) disable iff (!rst)
        (sck_rise || ws_fall) |-> !(sck_rise && ws_fall) ##1 !sck_rise ##1 !sck_rise);

endmodule

`default_nettype wire

/* i2si_pkg.sv */
`default_nettype none

`include "i2si_consts.svh"

package i2si_pkg;

    // One channel value, two's complement as sent on the wire
    typedef logic signed [`I2SI_SAMPLE_W-1:0] sample_t;

    // Source lane of a frame
    typedef logic [1:0] lane_t;

    // Stereo frame as stored in the FIFO
    // Lane sits in the top bits, right sample in the low bits
    typedef struct packed {
        lane_t   lane;      // Which sd pin
        sample_t left;      // ws low word
        sample_t right;     // ws high word
    } frame_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module i2s_in_tb -f verilog.f -o sim_i2s_in \
    && ./obj_dir/sim_i2s_in || exit 1

/* verilog.f */
+incdir+.
i2si_pkg.sv
i2si_frame_if.sv
i2si_pin_sync.sv
i2si_deserializer.sv
i2si_bist_gen.sv
i2si_collector.sv
i2si_fifo.sv
i2s_in.sv
i2s_in_tb.sv
